// File: src/calc_params.svh
`ifndef CALC_PARAMS_SVH
`define CALC_PARAMS_SVH

// width of one stack value
`define CALC_DATA_W 8

// stack address and pointer width
`define CALC_ADDR_W 7

// entries in the stack memory
`define CALC_DEPTH 128

// pointer value of an empty stack
// the stack grows downward from this address
`define CALC_STACK_TOP 7'h7F

`endif

// File: src/calcDataPkg.sv
`include "calc_params.svh"

package calcDataPkg;

    // one entry on the stack
    typedef logic [`CALC_DATA_W-1:0] value_t;

    // memory address, also used for both pointers
    typedef logic [`CALC_ADDR_W-1:0] stackAddr_t;

    // command strobe code
    // cmdNone means no strobe in this cycle
    typedef enum logic [2:0] {
        cmdNone       = 3'd0,
        cmdPush       = 3'd1,
        cmdPop        = 3'd2,
        cmdAdd        = 3'd3,
        cmdSub        = 3'd4,
        cmdClear      = 3'd5,
        cmdBrowseUp   = 3'd6,
        cmdBrowseDown = 3'd7
    } cmd_t;

endpackage

// File: src/calcUcodePkg.sv
package calcUcodePkg;

    // microcode state, doubles as the ROM index
    typedef enum logic [4:0] {
        stWait    = 5'd0,
        stClear   = 5'd1,
        stPush    = 5'd2,
        stSprDec  = 5'd3,
        stDarTop  = 5'd4,
        stRequest = 5'd5,
        stLoad    = 5'd6,
        stPop     = 5'd7,
        stIncB    = 5'd8,
        stReqB    = 5'd9,
        stLoadB   = 5'd10,
        stIncA    = 5'd11,
        stReqA    = 5'd12,
        stLoadA   = 5'd13,
        stStore   = 5'd14,
        stDarDec  = 5'd15,
        stDarInc  = 5'd16
    } state_t;

    // stack pointer source
    typedef enum logic [1:0] {
        sprInit = 2'd0,
        sprDec  = 2'd1,
        sprInc  = 2'd2
    } sprSel_t;

    // display pointer source
    typedef enum logic [1:0] {
        darInit   = 2'd0,
        darSprInc = 2'd1,
        darDec    = 2'd2,
        darInc    = 2'd3
    } darSel_t;

    // value register source
    typedef enum logic [1:0] {
        valZero = 2'd0,
        valRead = 2'd1,
        valAlu  = 2'd2
    } valSel_t;

    // addrSel high puts the display pointer on the memory address
    typedef struct packed {
        sprSel_t sprSel;
        logic    sprLoad;
        darSel_t darSel;
        logic    darLoad;
        logic    addrSel;
    } ptrCtrl_t;

    typedef struct packed {
        valSel_t valSel;
        logic    valLoad;
        logic    opALoad;
        logic    opBLoad;
        logic    aluSub;
        logic    wrSelAlu;
    } valCtrl_t;

    typedef struct packed {
        logic cs;
        logic we;
    } memCtrl_t;

endpackage

// File: src/stackRam.sv
`timescale 1ns/1ps
`include "calc_params.svh"

module stackRam
    import calcDataPkg::*;
    import calcUcodePkg::*;
(
    input  logic       clk,
    input  memCtrl_t   memCtrl,
    input  stackAddr_t addr,
    input  value_t     wrData,
    output value_t     rdData
);

    value_t mem [`CALC_DEPTH];

    // single port
    // write when cs and we, otherwise a read registered for the next cycle
    always_ff @(posedge clk) begin
        if (memCtrl.cs) begin
            if (memCtrl.we) begin
                mem[addr] <= wrData;
            end else begin
                rdData <= mem[addr];
            end
        end
    end

endmodule

// File: src/stackPointers.sv
`timescale 1ns/1ps
`include "calc_params.svh"

module stackPointers
    import calcDataPkg::*;
    import calcUcodePkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  ptrCtrl_t   ptrCtrl,
    output stackAddr_t addr,
    output stackAddr_t browseAddr,
    output logic       empty
);

    // spr points at the next free slot
    stackAddr_t spr;
    // dar points at the entry shown
    stackAddr_t dar;
    stackAddr_t sprNext;
    stackAddr_t darNext;

    always_comb begin
        case (ptrCtrl.sprSel)
            sprDec:  sprNext = spr - 1'b1;
            sprInc:  sprNext = spr + 1'b1;
            default: sprNext = `CALC_STACK_TOP;
        endcase
    end

    always_comb begin
        case (ptrCtrl.darSel)
            // top entry sits just above the free slot
            darSprInc: darNext = spr + 1'b1;
            darDec:    darNext = dar - 1'b1;
            darInc:    darNext = dar + 1'b1;
            default:   darNext = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            spr <= `CALC_STACK_TOP;
            dar <= '0;
        end else begin
            if (ptrCtrl.sprLoad) begin
                spr <= sprNext;
            end
            if (ptrCtrl.darLoad) begin
                dar <= darNext;
            end
        end
    end

    assign addr       = ptrCtrl.addrSel ? dar : spr;
    assign browseAddr = dar;
    assign empty      = (spr == `CALC_STACK_TOP);

    // no wrap in either direction
    assert property (@(posedge clk) disable iff (!arstN)
        (ptrCtrl.sprLoad && ptrCtrl.sprSel == sprDec) |-> (spr != '0))
        else $error("stack pointer wrapped from 00 to 7F");

    assert property (@(posedge clk) disable iff (!arstN)
        (ptrCtrl.sprLoad && ptrCtrl.sprSel == sprInc) |-> (spr != `CALC_STACK_TOP))
        else $error("stack pointer wrapped from 7F to 00");

endmodule

// File: src/valueDatapath.sv
`timescale 1ns/1ps

module valueDatapath
    import calcDataPkg::*;
    import calcUcodePkg::*;
(
    input  logic     clk,
    input  logic     arstN,
    input  valCtrl_t valCtrl,
    input  value_t   switches,
    input  value_t   rdData,
    output value_t   value,
    output value_t   wrData
);

    // A is the minuend, B the old top
    value_t opA;
    value_t opB;
    value_t aluOut;
    value_t valNext;

    // both operands come straight from the memory read data
    always_ff @(posedge clk) begin
        if (valCtrl.opALoad) begin
            opA <= rdData;
        end
        if (valCtrl.opBLoad) begin
            opB <= rdData;
        end
    end

    // wraps modulo 256
    assign aluOut = valCtrl.aluSub ? (opA - opB) : (opA + opB);

    always_comb begin
        case (valCtrl.valSel)
            valRead: valNext = rdData;
            valAlu:  valNext = aluOut;
            default: valNext = '0;
        endcase
    end

    // shown value
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            value <= '0;
        end else if (valCtrl.valLoad) begin
            value <= valNext;
        end
    end

    assign wrData = valCtrl.wrSelAlu ? aluOut : switches;

endmodule

// File: src/calcSequencer.sv
`timescale 1ns/1ps

module calcSequencer
    import calcDataPkg::*;
    import calcUcodePkg::*;
(
    input  logic     clk,
    input  logic     arstN,
    input  cmd_t     cmd,
    output ptrCtrl_t ptrCtrl,
    output valCtrl_t valCtrl,
    output memCtrl_t memCtrl,
    output logic     busy
);

    // one control word per state
    typedef struct packed {
        state_t   next;
        logic     fromCmd;
        ptrCtrl_t ptr;
        valCtrl_t val;
        memCtrl_t mem;
    } ucodeWord_t;

    localparam ptrCtrl_t ptrIdle    = '{sprInit, 1'b0, darInit, 1'b0, 1'b0};
    localparam ptrCtrl_t ptrSprDec  = '{sprDec, 1'b1, darInit, 1'b0, 1'b0};
    localparam ptrCtrl_t ptrSprInc  = '{sprInc, 1'b1, darInit, 1'b0, 1'b0};
    localparam ptrCtrl_t ptrDarAddr = '{sprInit, 1'b0, darInit, 1'b0, 1'b1};
    localparam valCtrl_t valIdle    = '{valZero, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
    localparam memCtrl_t memIdle    = '{1'b0, 1'b0};
    localparam memCtrl_t memRead    = '{1'b1, 1'b0};
    localparam memCtrl_t memWrite   = '{1'b1, 1'b1};

    state_t     state;
    state_t     nextState;
    ucodeWord_t word;
    logic       subOp;

    // the microcode ROM
    function automatic ucodeWord_t romWord(input state_t s);
        case (s)
            stWait:    return '{stWait, 1'b1, ptrIdle, valIdle, memIdle};
            stClear:   return '{stWait, 1'b0, '{sprInit, 1'b1, darInit, 1'b1, 1'b0},
                                '{valZero, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0}, memIdle};
            // push writes the switches at the free slot
            stPush:    return '{stSprDec, 1'b0, ptrIdle, valIdle, memWrite};
            // shared tail, point the display at the top and read it back
            stSprDec:  return '{stDarTop, 1'b0, ptrSprDec, valIdle, memIdle};
            stDarTop:  return '{stRequest, 1'b0, '{sprInit, 1'b0, darSprInc, 1'b1, 1'b1},
                                valIdle, memIdle};
            stRequest: return '{stLoad, 1'b0, ptrDarAddr, valIdle, memRead};
            stLoad:    return '{stWait, 1'b0, ptrDarAddr,
                                '{valRead, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0}, memIdle};
            stPop:     return '{stDarTop, 1'b0, ptrSprInc, valIdle, memIdle};
            // fetch B, the old top
            stIncB:    return '{stReqB, 1'b0, ptrSprInc, valIdle, memIdle};
            stReqB:    return '{stLoadB, 1'b0, ptrIdle, valIdle, memRead};
            stLoadB:   return '{stIncA, 1'b0, ptrIdle,
                                '{valZero, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0}, memIdle};
            // then A, the entry below it
            stIncA:    return '{stReqA, 1'b0, ptrSprInc, valIdle, memIdle};
            stReqA:    return '{stLoadA, 1'b0, ptrIdle, valIdle, memRead};
            stLoadA:   return '{stStore, 1'b0, ptrIdle,
                                '{valZero, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0}, memIdle};
            // result overwrites A, then the push tail makes it the top
            stStore:   return '{stSprDec, 1'b0, ptrIdle,
                                '{valZero, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1}, memWrite};
            stDarDec:  return '{stRequest, 1'b0, '{sprInit, 1'b0, darDec, 1'b1, 1'b1},
                                valIdle, memIdle};
            stDarInc:  return '{stRequest, 1'b0, '{sprInit, 1'b0, darInc, 1'b1, 1'b1},
                                valIdle, memIdle};
            default:   return '{stWait, 1'b0, ptrIdle, valIdle, memIdle};
        endcase
    endfunction

    assign word = romWord(state);

    // command entry only from the wait word
    always_comb begin
        nextState = word.next;
        if (word.fromCmd) begin
            case (cmd)
                cmdPush:        nextState = stPush;
                cmdPop:         nextState = stPop;
                cmdAdd, cmdSub: nextState = stIncB;
                cmdClear:       nextState = stClear;
                cmdBrowseUp:    nextState = stDarInc;
                cmdBrowseDown:  nextState = stDarDec;
                default:        nextState = stWait;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stWait;
            subOp <= 1'b0;
        end else begin
            state <= nextState;
            // add and sub share one sequence, remember which one
            if (word.fromCmd && cmd != cmdNone) begin
                subOp <= (cmd == cmdSub);
            end
        end
    end

    assign ptrCtrl = word.ptr;
    assign memCtrl = word.mem;
    assign busy    = (state != stWait);

    // rom bit marks where the ALU result is used
    always_comb begin
        valCtrl        = word.val;
        valCtrl.aluSub = word.val.aluSub & subOp;
    end

    // a strobe during a command neither redirects it nor changes its operation
    assert property (@(posedge clk) disable iff (!arstN)
        (busy && cmd != cmdNone) |=> (state == $past(word.next)) && $stable(subOp))
        else $error("sequencer redirected by strobe while busy");

    assert property (@(posedge clk) disable iff (!arstN)
        state inside {[stWait:stDarInc]})
        else $error("sequencer state outside the microcode");

endmodule

// File: src/calcTop.sv
`timescale 1ns/1ps

module calcTop
    import calcDataPkg::*;
    import calcUcodePkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  cmd_t       cmd,
    input  value_t     switches,
    output value_t     value,
    output stackAddr_t browseAddr,
    output logic       empty,
    output logic       busy
);

    ptrCtrl_t   ptrCtrl;
    valCtrl_t   valCtrl;
    memCtrl_t   memCtrl;
    stackAddr_t addr;
    value_t     wrData;
    value_t     rdData;

    calcSequencer i_calcSequencer (
        .clk     (clk),
        .arstN   (arstN),
        .cmd     (cmd),
        .ptrCtrl (ptrCtrl),
        .valCtrl (valCtrl),
        .memCtrl (memCtrl),
        .busy    (busy)
    );

    stackPointers i_stackPointers (
        .clk        (clk),
        .arstN      (arstN),
        .ptrCtrl    (ptrCtrl),
        .addr       (addr),
        .browseAddr (browseAddr),
        .empty      (empty)
    );

    valueDatapath i_valueDatapath (
        .clk      (clk),
        .arstN    (arstN),
        .valCtrl  (valCtrl),
        .switches (switches),
        .rdData   (rdData),
        .value    (value),
        .wrData   (wrData)
    );

    // stack storage, internal to the design
    stackRam i_stackRam (
        .clk     (clk),
        .memCtrl (memCtrl),
        .addr    (addr),
        .wrData  (wrData),
        .rdData  (rdData)
    );

endmodule

// File: dv/calcTb.sv
`timescale 1ns/1ps
`include "calc_params.svh"

module calcTb
    import calcDataPkg::*;
();

    localparam int numCmds = 200;
    localparam int maxDepth = 20;
    // longest command plus the idle and accept cycles around it
    localparam int maxBusyCycles = 11;
    localparam int cmdOverhead = 2;
    localparam int cycleLimit = numCmds * (maxBusyCycles + cmdOverhead) + 400;
    localparam int unsigned rngSeed = 32'h81e2_0b44;
    localparam int stackTop = int'(`CALC_STACK_TOP);

    logic       clk;
    logic       arstN;
    cmd_t       cmd;
    value_t     switches;
    value_t     value;
    stackAddr_t browseAddr;
    logic       empty;
    logic       busy;

    // reference stack, last element is the top
    value_t stackQ[$];
    // expected display pointer
    int expDar = 0;
    int errCount = 0;
    int checkCount = 0;
    int junkCount = 0;
    int cycleCount = 0;

    calcTop i_calcTop (
        .clk        (clk),
        .arstN      (arstN),
        .cmd        (cmd),
        .switches   (switches),
        .value      (value),
        .browseAddr (browseAddr),
        .empty      (empty),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // hang guard
    initial begin
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: run did not complete within %0d clock cycles", cycleLimit);
        $display("Finished with errors");
        $finish;
    end

    task automatic checkEq(input string sigName, input int expVal, input int actVal);
        checkCount++;
        assert (actVal == expVal)
        else begin
            errCount++;
            $display("ERROR at %0t ns: %s expected %0h, got %0h",
                     $time, sigName, expVal, actVal);
        end
    endtask

    // busy length of each command after acceptance
    function automatic int cmdCycles(input cmd_t c);
        case (c)
            cmdClear:                   return 1;
            cmdBrowseUp, cmdBrowseDown: return 3;
            cmdPop:                     return 4;
            cmdPush:                    return 5;
            cmdAdd, cmdSub:             return 11;
            default:                    return 0;
        endcase
    endfunction

    // address of the top entry for a given depth, wraps to 00 when empty
    function automatic int topAddr(input int depth);
        return (stackTop + 1 - depth) % `CALC_DEPTH;
    endfunction

    // keeps the depth within 0..maxDepth and browsing inside live entries
    function automatic cmd_t pickCommand(input int depth, input int dar);
        int   r;
        int   lowAddr;
        logic canUp;
        logic canDown;
        r = $urandom_range(99, 0);
        lowAddr = topAddr(depth);
        canUp = (depth > 0) && (dar >= lowAddr) && (dar < stackTop);
        canDown = (depth > 0) && (dar > lowAddr) && (dar <= stackTop);
        if (depth == 0) begin
            return (r < 10) ? cmdClear : cmdPush;
        end
        if (r < 30 && depth < maxDepth) return cmdPush;
        if (r >= 30 && r < 45) return cmdPop;
        if (r >= 45 && r < 55 && depth >= 2) return cmdAdd;
        if (r >= 55 && r < 65 && depth >= 2) return cmdSub;
        if (r >= 65 && r < 77 && canUp) return cmdBrowseUp;
        if (r >= 77 && r < 89 && canDown) return cmdBrowseDown;
        if (r >= 89 && r < 92) return cmdClear;
        return (depth < maxDepth) ? cmdPush : cmdPop;
    endfunction

    // update the reference stack and compare the DUT outputs
    task automatic applyAndCheck(input cmd_t c, input value_t sw, input int cycles);
        value_t a;
        value_t b;
        value_t res;
        checkEq("busy cycles", cmdCycles(c), cycles);
        case (c)
            cmdPush: begin
                stackQ.push_back(sw);
                expDar = topAddr(stackQ.size());
                checkEq("value", int'(sw), int'(value));
                checkEq("empty", 0, int'(empty));
                checkEq("browseAddr", expDar, int'(browseAddr));
            end
            cmdPop: begin
                a = stackQ.pop_back();
                expDar = topAddr(stackQ.size());
                if (stackQ.size() > 0) begin
                    checkEq("value", int'(stackQ[$]), int'(value));
                    checkEq("empty", 0, int'(empty));
                    checkEq("browseAddr", expDar, int'(browseAddr));
                end else begin
                    // last entry gone, shown value is don't care
                    checkEq("empty", 1, int'(empty));
                end
            end
            cmdAdd, cmdSub: begin
                // B is the old top, A the entry below and the minuend
                b = stackQ.pop_back();
                a = stackQ.pop_back();
                res = (c == cmdSub) ? a - b : a + b;
                stackQ.push_back(res);
                expDar = topAddr(stackQ.size());
                checkEq("value", int'(res), int'(value));
                checkEq("empty", 0, int'(empty));
                checkEq("browseAddr", expDar, int'(browseAddr));
            end
            cmdBrowseUp, cmdBrowseDown: begin
                expDar = (c == cmdBrowseUp) ? expDar + 1 : expDar - 1;
                checkEq("browseAddr", expDar, int'(browseAddr));
                checkEq("value", int'(stackQ[stackTop - expDar]), int'(value));
            end
            cmdClear: begin
                stackQ.delete();
                expDar = 0;
                checkEq("empty", 1, int'(empty));
                checkEq("value", 0, int'(value));
            end
            default: begin
                errCount++;
                $display("stimulus issued a command code with no expected behavior");
            end
        endcase
    endtask

    // one strobe, then wait for busy to fall
    // withJunk throws extra strobes at the DUT while it is busy
    task automatic runCommand(input cmd_t c, input value_t sw, input logic withJunk);
        int busyCycles;
        @(negedge clk);
        checkEq("busy", 0, int'(busy));
        cmd = c;
        switches = sw;
        @(negedge clk);
        busyCycles = 0;
        while (busy) begin
            busyCycles++;
            if (withJunk) begin
                cmd = cmd_t'(3'($urandom_range(7, 1)));
                junkCount++;
            end else begin
                cmd = cmdNone;
            end
            @(negedge clk);
        end
        cmd = cmdNone;
        applyAndCheck(c, sw, busyCycles);
    endtask

    initial begin
        int unsigned seedDummy;
        cmd_t        c;
        value_t      sw;
        logic        withJunk;
        arstN = 1'b0;
        cmd = cmdNone;
        switches = '0;
        seedDummy = $urandom(rngSeed);
        repeat (4) @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);

        // state right after reset
        checkEq("busy", 0, int'(busy));
        checkEq("value", 0, int'(value));
        checkEq("empty", 1, int'(empty));

        runCommand(cmdClear, '0, 1'b0);
        for (int i = 0; i < numCmds; i++) begin
            c = pickCommand(stackQ.size(), expDar);
            sw = value_t'($urandom());
            withJunk = ($urandom_range(3, 0) == 0);
            runCommand(c, sw, withJunk);
        end
        @(negedge clk);

        $display("%0d checks, %0d errors, %0d strobes while busy",
                 checkCount, errCount, junkCount);
        if (errCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+src
src/calcDataPkg.sv
src/calcUcodePkg.sv
src/stackRam.sv
src/stackPointers.sv
src/valueDatapath.sv
src/calcSequencer.sv
src/calcTop.sv
dv/calcTb.sv

// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module calcTb -f compile.f \
		--Mdir obj_dir -o calcSim

run: compile
	@out="$$(./obj_dir/calcSim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir
